// File: include/tsc_defs.svh
`ifndef TSC_DEFS_SVH
`define TSC_DEFS_SVH

`define TSC_WORD_SIZE   16
`define TSC_REG_BITS    2
`define TSC_MEM_DEPTH   256

// Instruction field positions
`define TSC_OPCODE_HI   15
`define TSC_OPCODE_BITS 4
`define TSC_RS_HI       11
`define TSC_RT_HI       9
`define TSC_RD_HI       7
`define TSC_FUNC_BITS   6
`define TSC_IMM_BITS    8
`define TSC_TARGET_BITS 12

`endif

// File: hw/tsc_pkg.sv
`include "tsc_defs.svh"

package tsc_pkg;

	typedef enum logic [`TSC_OPCODE_BITS-1:0] {
		OP_BNE   = 4'd0,
		OP_BEQ   = 4'd1,
		OP_ADI   = 4'd4,
		OP_LWD   = 4'd7,
		OP_SWD   = 4'd8,
		OP_JMP   = 4'd9,
		OP_RTYPE = 4'd15
	} opcode_e;

	typedef enum logic [`TSC_FUNC_BITS-1:0] {
		FN_ADD = 6'd0,
		FN_SUB = 6'd1,
		FN_AND = 6'd2,
		FN_ORR = 6'd3,
		FN_NOT = 6'd4,
		FN_WWD = 6'd28,
		FN_HLT = 6'd29
	} func_e;

	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_NOT,
		ALU_PASS_B,
		ALU_CMP
	} alu_op_e;

	typedef enum logic [2:0] {
		FETCH,
		DECODE,
		EXEC,
		MEM,
		WB,
		OUT,
		HALT
	} state_e;

	typedef struct packed {
		logic                      write;
		logic [`TSC_WORD_SIZE-1:0] addr;
		logic [`TSC_WORD_SIZE-1:0] wdata;
	} mem_req_t;

	typedef struct packed {
		logic [`TSC_WORD_SIZE-1:0] rdata;
	} mem_rsp_t;

	// seq is the completed instruction count when WWD ran
	typedef struct packed {
		logic [`TSC_WORD_SIZE-1:0] value;
		logic [`TSC_WORD_SIZE-1:0] seq;
	} out_word_t;

endpackage

// File: hw/mem_port.sv
`timescale 1ns/1ps
`include "tsc_defs.svh"

module mem_port (
	input  logic                      clk,
	input  logic                      reset_n,
	input  logic                      start,
	input  tsc_pkg::mem_req_t         req_in,
	output logic                      done,
	output logic [`TSC_WORD_SIZE-1:0] rdata,
	output logic                      mem_req,
	output tsc_pkg::mem_req_t         mem_req_data,
	input  logic                      mem_ack,
	input  tsc_pkg::mem_rsp_t         mem_rsp
);

	typedef enum logic [1:0] {
		MP_IDLE,
		MP_WAIT_HI,
		MP_WAIT_LO
	} hs_state_e;

	hs_state_e state;

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			state   <= MP_IDLE;
			mem_req <= 1'b0;
		end else begin
			case (state)
				MP_IDLE: if (start) begin
					mem_req <= 1'b1;
					state   <= MP_WAIT_HI;
				end
				MP_WAIT_HI: if (mem_ack) begin
					mem_req <= 1'b0;
					state   <= MP_WAIT_LO;
				end
				MP_WAIT_LO: if (!mem_ack) begin
					state <= MP_IDLE;
				end
				default: state <= MP_IDLE;
			endcase
		end
	end

	// Request held from start, read word kept after done
	always_ff @(posedge clk) begin
		if (state == MP_IDLE && start)
			mem_req_data <= req_in;
		if (state == MP_WAIT_HI && mem_ack)
			rdata <= mem_rsp.rdata;
	end

	assign done = (state == MP_WAIT_LO) && !mem_ack;

	a_start_idle: assert property (@(posedge clk) disable iff (!reset_n)
		start |-> state == MP_IDLE);

	a_req_stable: assert property (@(posedge clk) disable iff (!reset_n)
		mem_req && $past(mem_req) |-> $stable(mem_req_data));

endmodule

// File: hw/register_file.sv
`timescale 1ns/1ps
`include "tsc_defs.svh"

module register_file (
	input  logic                      clk,
	input  logic                      reset_n,
	input  logic [`TSC_REG_BITS-1:0]  rs,
	input  logic [`TSC_REG_BITS-1:0]  rt,
	input  logic [`TSC_REG_BITS-1:0]  wr_idx,
	input  logic [`TSC_WORD_SIZE-1:0] wr_data,
	input  logic                      wr_en,
	output logic [`TSC_WORD_SIZE-1:0] rs_data,
	output logic [`TSC_WORD_SIZE-1:0] rt_data
);

	logic [`TSC_WORD_SIZE-1:0] regs [1<<`TSC_REG_BITS];

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			for (int i = 0; i < (1 << `TSC_REG_BITS); i++)
				regs[i] <= '0;
		end else if (wr_en) begin
			regs[wr_idx] <= wr_data;
		end
	end

	assign rs_data = regs[rs];
	assign rt_data = regs[rt];

endmodule

// File: hw/alu.sv
`timescale 1ns/1ps
`include "tsc_defs.svh"

module alu (
	input  logic [`TSC_WORD_SIZE-1:0] a,
	input  logic [`TSC_WORD_SIZE-1:0] b,
	input  tsc_pkg::alu_op_e          op,
	output logic [`TSC_WORD_SIZE-1:0] result,
	output logic                      equal
);

	import tsc_pkg::*;

	always_comb begin
		case (op)
			ALU_ADD:    result = a + b;
			ALU_SUB,
			ALU_CMP:    result = a - b;
			ALU_AND:    result = a & b;
			ALU_OR:     result = a | b;
			ALU_NOT:    result = ~a;
			ALU_PASS_B: result = b;
			default:    result = '0;
		endcase
	end

	// Branch condition for BEQ and BNE
	assign equal = (a == b);

endmodule

// File: hw/control_fsm.sv
`timescale 1ns/1ps

module control_fsm (
	input  logic               clk,
	input  logic               reset_n,
	input  tsc_pkg::opcode_e   opcode,
	input  tsc_pkg::func_e     func,
	input  logic               equal,
	input  logic               mem_done,
	input  logic               out_busy,
	output logic               mem_start,
	output logic               mem_write,
	output logic               addr_from_alu,
	output logic               ir_load,
	output logic               mdr_load,
	output logic               pc_load,
	output logic [1:0]         pc_src,
	output logic               alu_a_pc,
	output logic [1:0]         alu_b_sel,
	output tsc_pkg::alu_op_e   alu_op,
	output logic               reg_write,
	output logic               wr_from_mem,
	output logic               wr_to_rt,
	output logic               inst_done,
	output logic               out_start,
	output logic               halted
);

	import tsc_pkg::*;

	localparam logic [1:0] PC_ALU    = 2'd0;
	localparam logic [1:0] PC_ALUOUT = 2'd1;
	localparam logic [1:0] PC_JUMP   = 2'd2;
	localparam logic [1:0] B_REG     = 2'd0;
	localparam logic [1:0] B_ONE     = 2'd1;
	localparam logic [1:0] B_IMM     = 2'd2;

	state_e state;
	state_e next_state;
	logic   mem_pending;
	logic   alu_func;

	// R-type functions that go through EXEC and WB
	assign alu_func = func inside {FN_ADD, FN_SUB, FN_AND, FN_ORR, FN_NOT};

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			state       <= FETCH;
			mem_pending <= 1'b0;
		end else begin
			state <= next_state;
			if (mem_done)
				mem_pending <= 1'b0;
			else if (mem_start)
				mem_pending <= 1'b1;
		end
	end

	always_comb begin
		next_state    = state;
		mem_start     = 1'b0;
		mem_write     = 1'b0;
		addr_from_alu = 1'b0;
		ir_load       = 1'b0;
		mdr_load      = 1'b0;
		pc_load       = 1'b0;
		pc_src        = PC_ALU;
		alu_a_pc      = 1'b0;
		alu_b_sel     = B_REG;
		alu_op        = ALU_PASS_B;
		reg_write     = 1'b0;
		wr_from_mem   = opcode == OP_LWD;
		wr_to_rt      = opcode != OP_RTYPE;
		inst_done     = 1'b0;
		out_start     = 1'b0;
		case (state)
			FETCH: begin
				mem_start = !mem_pending;
				// PC+1 written back as the word arrives
				alu_a_pc  = 1'b1;
				alu_b_sel = B_ONE;
				alu_op    = ALU_ADD;
				if (mem_done) begin
					ir_load    = 1'b1;
					pc_load    = 1'b1;
					next_state = DECODE;
				end
			end
			DECODE: begin
				// Branch target into ALUOut
				alu_a_pc  = 1'b1;
				alu_b_sel = B_IMM;
				alu_op    = ALU_ADD;
				next_state = EXEC;
				if (opcode == OP_RTYPE) begin
					if (func == FN_WWD) begin
						next_state = OUT;
					end else if (func == FN_HLT) begin
						inst_done  = 1'b1;
						next_state = HALT;
					end else if (!alu_func) begin
						inst_done  = 1'b1;
						next_state = FETCH;
					end
				end else if (!(opcode inside {OP_BNE, OP_BEQ, OP_ADI, OP_LWD, OP_SWD,
						OP_JMP})) begin
					inst_done  = 1'b1;
					next_state = FETCH;
				end
			end
			EXEC: begin
				case (opcode)
					OP_RTYPE: begin
						case (func)
							FN_SUB:  alu_op = ALU_SUB;
							FN_AND:  alu_op = ALU_AND;
							FN_ORR:  alu_op = ALU_OR;
							FN_NOT:  alu_op = ALU_NOT;
							default: alu_op = ALU_ADD;
						endcase
						next_state = WB;
					end
					OP_ADI, OP_LWD, OP_SWD: begin
						alu_b_sel  = B_IMM;
						alu_op     = ALU_ADD;
						next_state = (opcode == OP_ADI) ? WB : MEM;
					end
					OP_BEQ, OP_BNE: begin
						alu_op     = ALU_CMP;
						pc_src     = PC_ALUOUT;
						pc_load    = (opcode == OP_BEQ) ? equal : !equal;
						inst_done  = 1'b1;
						next_state = FETCH;
					end
					default: begin
						pc_src     = PC_JUMP;
						pc_load    = 1'b1;
						inst_done  = 1'b1;
						next_state = FETCH;
					end
				endcase
			end
			MEM: begin
				// Keep the address computation in place
				alu_b_sel     = B_IMM;
				alu_op        = ALU_ADD;
				addr_from_alu = 1'b1;
				mem_write     = opcode == OP_SWD;
				mem_start     = !mem_pending;
				if (mem_done) begin
					if (opcode == OP_LWD) begin
						mdr_load   = 1'b1;
						next_state = WB;
					end else begin
						inst_done  = 1'b1;
						next_state = FETCH;
					end
				end
			end
			WB: begin
				reg_write  = 1'b1;
				inst_done  = 1'b1;
				next_state = FETCH;
			end
			OUT: if (!out_busy) begin
				out_start  = 1'b1;
				inst_done  = 1'b1;
				next_state = FETCH;
			end
			HALT: next_state = HALT;
			default: next_state = FETCH;
		endcase
	end

	assign halted = (state == HALT);

	a_mem_start_state: assert property (@(posedge clk) disable iff (!reset_n)
		mem_start |-> state inside {FETCH, MEM});

endmodule

// File: hw/datapath.sv
`timescale 1ns/1ps
`include "tsc_defs.svh"

module datapath (
	input  logic                      clk,
	input  logic                      reset_n,
	input  logic                      mem_write,
	input  logic                      addr_from_alu,
	input  logic                      ir_load,
	input  logic                      mdr_load,
	input  logic                      pc_load,
	input  logic [1:0]                pc_src,
	input  logic                      alu_a_pc,
	input  logic [1:0]                alu_b_sel,
	input  tsc_pkg::alu_op_e          alu_op,
	input  logic                      reg_write,
	input  logic                      wr_from_mem,
	input  logic                      wr_to_rt,
	input  logic                      inst_done,
	input  logic [`TSC_WORD_SIZE-1:0] mem_rdata,
	output tsc_pkg::mem_req_t         mem_req_out,
	output tsc_pkg::opcode_e          opcode,
	output tsc_pkg::func_e            func,
	output logic                      equal,
	output logic [`TSC_WORD_SIZE-1:0] wwd_value,
	output logic [`TSC_WORD_SIZE-1:0] num_inst
);

	import tsc_pkg::*;

	logic [`TSC_WORD_SIZE-1:0] pc;
	logic [`TSC_WORD_SIZE-1:0] ir;
	logic [`TSC_WORD_SIZE-1:0] mdr;
	logic [`TSC_WORD_SIZE-1:0] a_reg;
	logic [`TSC_WORD_SIZE-1:0] b_reg;
	logic [`TSC_WORD_SIZE-1:0] alu_out;
	logic [`TSC_WORD_SIZE-1:0] inst_count;
	logic [`TSC_WORD_SIZE-1:0] rs_data;
	logic [`TSC_WORD_SIZE-1:0] rt_data;
	logic [`TSC_WORD_SIZE-1:0] alu_a;
	logic [`TSC_WORD_SIZE-1:0] alu_b;
	logic [`TSC_WORD_SIZE-1:0] alu_result;
	logic [`TSC_WORD_SIZE-1:0] imm_ext;
	logic [`TSC_WORD_SIZE-1:0] jump_target;
	logic [`TSC_WORD_SIZE-1:0] pc_next;
	logic [`TSC_WORD_SIZE-1:0] wr_data;
	logic [`TSC_REG_BITS-1:0]  rs_idx;
	logic [`TSC_REG_BITS-1:0]  rt_idx;
	logic [`TSC_REG_BITS-1:0]  rd_idx;
	logic [`TSC_REG_BITS-1:0]  wr_idx;

	assign opcode = opcode_e'(ir[`TSC_OPCODE_HI -: `TSC_OPCODE_BITS]);
	assign func   = func_e'(ir[`TSC_FUNC_BITS-1:0]);
	assign rs_idx = ir[`TSC_RS_HI -: `TSC_REG_BITS];
	assign rt_idx = ir[`TSC_RT_HI -: `TSC_REG_BITS];
	assign rd_idx = ir[`TSC_RD_HI -: `TSC_REG_BITS];

	assign imm_ext = {{(`TSC_WORD_SIZE - `TSC_IMM_BITS){ir[`TSC_IMM_BITS-1]}},
		ir[`TSC_IMM_BITS-1:0]};
	assign jump_target = {pc[`TSC_WORD_SIZE-1:`TSC_TARGET_BITS], ir[`TSC_TARGET_BITS-1:0]};

	always_comb begin
		case (alu_b_sel)
			2'd0:    alu_b = b_reg;
			2'd1:    alu_b = `TSC_WORD_SIZE'(1);
			default: alu_b = imm_ext;
		endcase
		case (pc_src)
			2'd0:    pc_next = alu_result;
			2'd1:    pc_next = alu_out;
			default: pc_next = jump_target;
		endcase
	end

	assign alu_a   = alu_a_pc ? pc : a_reg;
	assign wr_idx  = wr_to_rt ? rt_idx : rd_idx;
	assign wr_data = wr_from_mem ? mdr : alu_out;

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			pc         <= '0;
			inst_count <= '0;
		end else begin
			if (pc_load)
				pc <= pc_next;
			if (inst_done)
				inst_count <= inst_count + 1'b1;
		end
	end

	// Inter-state registers, A, B and ALUOut follow every cycle
	always_ff @(posedge clk) begin
		if (ir_load)
			ir <= mem_rdata;
		if (mdr_load)
			mdr <= mem_rdata;
		a_reg   <= rs_data;
		b_reg   <= rt_data;
		alu_out <= alu_result;
	end

	assign mem_req_out.write = mem_write;
	assign mem_req_out.addr  = addr_from_alu ? alu_out : pc;
	assign mem_req_out.wdata = b_reg;

	assign wwd_value = a_reg;
	assign num_inst  = inst_count;

	register_file u_regs (
		.clk     (clk),
		.reset_n (reset_n),
		.rs      (rs_idx),
		.rt      (rt_idx),
		.wr_idx  (wr_idx),
		.wr_data (wr_data),
		.wr_en   (reg_write),
		.rs_data (rs_data),
		.rt_data (rt_data)
	);

	alu u_alu (
		.a      (alu_a),
		.b      (alu_b),
		.op     (alu_op),
		.result (alu_result),
		.equal  (equal)
	);

endmodule

// File: hw/output_port.sv
`timescale 1ns/1ps
`include "tsc_defs.svh"

module output_port (
	input  logic                      clk,
	input  logic                      reset_n,
	input  logic                      start,
	input  logic [`TSC_WORD_SIZE-1:0] value,
	input  logic [`TSC_WORD_SIZE-1:0] seq,
	output logic                      busy,
	output logic                      out_req,
	output tsc_pkg::out_word_t        out_data,
	input  logic                      out_ack
);

	typedef enum logic [1:0] {
		PORT_IDLE,
		PORT_WAIT_HI,
		PORT_WAIT_LO
	} port_state_e;

	port_state_e state;

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			state   <= PORT_IDLE;
			out_req <= 1'b0;
		end else begin
			case (state)
				PORT_IDLE: if (start) begin
					out_req <= 1'b1;
					state   <= PORT_WAIT_HI;
				end
				PORT_WAIT_HI: if (out_ack) begin
					out_req <= 1'b0;
					state   <= PORT_WAIT_LO;
				end
				PORT_WAIT_LO: if (!out_ack) begin
					state <= PORT_IDLE;
				end
				default: state <= PORT_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == PORT_IDLE && start) begin
			out_data.value <= value;
			out_data.seq   <= seq;
		end
	end

	// Busy until the outside has released ack
	assign busy = (state != PORT_IDLE);

	a_data_stable: assert property (@(posedge clk) disable iff (!reset_n)
		out_req && $past(out_req) |-> $stable(out_data));

endmodule

// File: hw/tsc_cpu.sv
`timescale 1ns/1ps
`include "tsc_defs.svh"

module tsc_cpu (
	input  logic                      clk,
	input  logic                      reset_n,
	output logic                      mem_req,
	output tsc_pkg::mem_req_t         mem_req_data,
	input  logic                      mem_ack,
	input  tsc_pkg::mem_rsp_t         mem_rsp,
	output logic                      out_req,
	output tsc_pkg::out_word_t        out_data,
	input  logic                      out_ack,
	output logic [`TSC_WORD_SIZE-1:0] num_inst,
	output logic                      is_halted
);

	import tsc_pkg::*;

	logic                      mem_start;
	logic                      mem_done;
	logic [`TSC_WORD_SIZE-1:0] mem_rdata;
	mem_req_t                  mem_req_int;
	logic                      mem_write;
	logic                      addr_from_alu;
	logic                      ir_load;
	logic                      mdr_load;
	logic                      pc_load;
	logic [1:0]                pc_src;
	logic                      alu_a_pc;
	logic [1:0]                alu_b_sel;
	alu_op_e                   alu_op;
	logic                      reg_write;
	logic                      wr_from_mem;
	logic                      wr_to_rt;
	logic                      inst_done;
	opcode_e                   opcode;
	func_e                     func;
	logic                      equal;
	logic                      out_start;
	logic                      out_busy;
	logic [`TSC_WORD_SIZE-1:0] wwd_value;

	mem_port u_mem_port (
		.clk          (clk),
		.reset_n      (reset_n),
		.start        (mem_start),
		.req_in       (mem_req_int),
		.done         (mem_done),
		.rdata        (mem_rdata),
		.mem_req      (mem_req),
		.mem_req_data (mem_req_data),
		.mem_ack      (mem_ack),
		.mem_rsp      (mem_rsp)
	);

	control_fsm u_ctrl (
		.clk           (clk),
		.reset_n       (reset_n),
		.opcode        (opcode),
		.func          (func),
		.equal         (equal),
		.mem_done      (mem_done),
		.out_busy      (out_busy),
		.mem_start     (mem_start),
		.mem_write     (mem_write),
		.addr_from_alu (addr_from_alu),
		.ir_load       (ir_load),
		.mdr_load      (mdr_load),
		.pc_load       (pc_load),
		.pc_src        (pc_src),
		.alu_a_pc      (alu_a_pc),
		.alu_b_sel     (alu_b_sel),
		.alu_op        (alu_op),
		.reg_write     (reg_write),
		.wr_from_mem   (wr_from_mem),
		.wr_to_rt      (wr_to_rt),
		.inst_done     (inst_done),
		.out_start     (out_start),
		.halted        (is_halted)
	);

	datapath u_dp (
		.clk           (clk),
		.reset_n       (reset_n),
		.mem_write     (mem_write),
		.addr_from_alu (addr_from_alu),
		.ir_load       (ir_load),
		.mdr_load      (mdr_load),
		.pc_load       (pc_load),
		.pc_src        (pc_src),
		.alu_a_pc      (alu_a_pc),
		.alu_b_sel     (alu_b_sel),
		.alu_op        (alu_op),
		.reg_write     (reg_write),
		.wr_from_mem   (wr_from_mem),
		.wr_to_rt      (wr_to_rt),
		.inst_done     (inst_done),
		.mem_rdata     (mem_rdata),
		.mem_req_out   (mem_req_int),
		.opcode        (opcode),
		.func          (func),
		.equal         (equal),
		.wwd_value     (wwd_value),
		.num_inst      (num_inst)
	);

	output_port u_out_port (
		.clk      (clk),
		.reset_n  (reset_n),
		.start    (out_start),
		.value    (wwd_value),
		.seq      (num_inst),
		.busy     (out_busy),
		.out_req  (out_req),
		.out_data (out_data),
		.out_ack  (out_ack)
	);

endmodule

// File: verif/mem_model.sv
`timescale 1ns/1ps
`include "tsc_defs.svh"

module mem_model (
	input  logic              clk,
	input  logic              reset_n,
	input  logic              mem_req,
	input  tsc_pkg::mem_req_t mem_req_data,
	output logic              mem_ack,
	output tsc_pkg::mem_rsp_t mem_rsp
);

	logic [`TSC_WORD_SIZE-1:0] mem [`TSC_MEM_DEPTH];
	integer                    seed;
	int unsigned               req_count;
	logic                      counting;
	logic [1:0]                delay_left;

	initial begin
		seed      = 32'h65e8a040;
		req_count = 0;
		mem_ack   = 1'b0;
		mem_rsp   = '0;
	end

	// Background words, distinct at every address
	task automatic fill_pattern();
		for (int i = 0; i < `TSC_MEM_DEPTH; i++)
			mem[i] <= {~i[7:0], i[7:0]};
	endtask

	task automatic load_word(input int addr, input logic [`TSC_WORD_SIZE-1:0] data);
		mem[addr % `TSC_MEM_DEPTH] <= data;
	endtask

	function automatic logic [`TSC_WORD_SIZE-1:0] read_word(input int addr);
		return mem[addr % `TSC_MEM_DEPTH];
	endfunction

	always @(posedge clk) begin
		if (!reset_n) begin
			mem_ack    <= 1'b0;
			counting   <= 1'b0;
			delay_left <= '0;
		end else if (mem_ack) begin
			// Release once the CPU has dropped its request
			if (!mem_req)
				mem_ack <= 1'b0;
		end else if (counting) begin
			if (delay_left == 0) begin
				counting      <= 1'b0;
				mem_ack       <= 1'b1;
				mem_rsp.rdata <= mem[mem_req_data.addr % `TSC_MEM_DEPTH];
				if (mem_req_data.write)
					mem[mem_req_data.addr % `TSC_MEM_DEPTH] <= mem_req_data.wdata;
			end else begin
				delay_left <= delay_left - 1'b1;
			end
		end else if (mem_req) begin
			counting   <= 1'b1;
			delay_left <= 2'($unsigned($random(seed)) % 4);
			req_count  <= req_count + 1;
		end
	end

endmodule

// File: verif/tb_tsc_cpu.sv
`timescale 1ns/1ps
`include "tsc_defs.svh"

module tb_tsc_cpu;

	import tsc_pkg::*;

	localparam int HALT_TIMEOUT = 3000;
	localparam int WORD_TIMEOUT = 300;

	logic                      clk;
	logic                      reset_n;
	logic                      mem_req;
	mem_req_t                  mem_req_data;
	logic                      mem_ack;
	mem_rsp_t                  mem_rsp;
	logic                      out_req;
	out_word_t                 out_data;
	logic                      out_ack;
	logic [`TSC_WORD_SIZE-1:0] num_inst;
	logic                      is_halted;

	logic [`TSC_WORD_SIZE-1:0] prog [$];
	out_word_t                 exp_words [$];
	out_word_t                 got_words [$];
	int                        path_len;
	int                        skip_left;
	bit                        ack_stall;
	integer                    seed;
	logic                      sink_wait;
	logic [1:0]                sink_delay;

	tsc_cpu dut (
		.clk          (clk),
		.reset_n      (reset_n),
		.mem_req      (mem_req),
		.mem_req_data (mem_req_data),
		.mem_ack      (mem_ack),
		.mem_rsp      (mem_rsp),
		.out_req      (out_req),
		.out_data     (out_data),
		.out_ack      (out_ack),
		.num_inst     (num_inst),
		.is_halted    (is_halted)
	);

	mem_model u_mem (
		.clk          (clk),
		.reset_n      (reset_n),
		.mem_req      (mem_req),
		.mem_req_data (mem_req_data),
		.mem_ack      (mem_ack),
		.mem_rsp      (mem_rsp)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// Output sink, acks each word after an optional random delay
	always @(posedge clk) begin
		if (!reset_n) begin
			out_ack    <= 1'b0;
			sink_wait  <= 1'b0;
			sink_delay <= '0;
		end else if (out_ack) begin
			if (!out_req)
				out_ack <= 1'b0;
		end else if (sink_wait) begin
			if (sink_delay == 0) begin
				sink_wait <= 1'b0;
				out_ack   <= 1'b1;
				got_words.push_back(out_data);
			end else begin
				sink_delay <= sink_delay - 1'b1;
			end
		end else if (out_req) begin
			sink_wait  <= 1'b1;
			sink_delay <= ack_stall ? 2'($unsigned($random(seed)) % 4) : 2'd0;
		end
	end

	task automatic fail_now(input string msg);
		$display("%s", msg);
		$display("=== FAIL ===");
		$fatal(1, "simulation stopped at the first failure");
	endtask

	task automatic check_word(input string name, input out_word_t exp, input out_word_t act);
		if (act !== exp)
			fail_now($sformatf("Error: %s expected value %h seq %h, actual value %h seq %h",
				name, exp.value, exp.seq, act.value, act.seq));
	endtask

	task automatic check_count(input string name, input logic [`TSC_WORD_SIZE-1:0] exp,
			input logic [`TSC_WORD_SIZE-1:0] act);
		if (act !== exp)
			fail_now($sformatf("Error: %s expected %h actual %h", name, exp, act));
	endtask

	task automatic check_mem(input logic [`TSC_WORD_SIZE-1:0] addr,
			input logic [`TSC_WORD_SIZE-1:0] exp);
		logic [`TSC_WORD_SIZE-1:0] act;
		act = u_mem.read_word(int'(addr));
		if (act !== exp)
			fail_now($sformatf("Error: mem[%h] expected %h actual %h", addr, exp, act));
	endtask

	function automatic logic [`TSC_WORD_SIZE-1:0] sext8(input logic [`TSC_IMM_BITS-1:0] imm);
		return {{(`TSC_WORD_SIZE - `TSC_IMM_BITS){imm[`TSC_IMM_BITS-1]}}, imm};
	endfunction

	function automatic logic [15:0] enc_r(input func_e fn, input logic [1:0] rs,
			input logic [1:0] rt, input logic [1:0] rd);
		return {OP_RTYPE, rs, rt, rd, fn};
	endfunction

	function automatic logic [15:0] enc_i(input opcode_e op, input logic [1:0] rs,
			input logic [1:0] rt, input logic [7:0] imm);
		return {op, rs, rt, imm};
	endfunction

	// Program builder, tracks which words the CPU really executes
	task automatic start_program();
		prog.delete();
		exp_words.delete();
		path_len  = 0;
		skip_left = 0;
	endtask

	task automatic add_inst(input logic [15:0] word);
		prog.push_back(word);
		if (skip_left > 0)
			skip_left--;
		else
			path_len++;
	endtask

	task automatic add_wwd(input logic [1:0] rs, input logic [15:0] value);
		out_word_t w;
		if (skip_left == 0) begin
			w.value = value;
			w.seq   = 16'(path_len);
			exp_words.push_back(w);
		end
		add_inst(enc_r(FN_WWD, rs, 2'd0, 2'd0));
	endtask

	task automatic add_marker(input logic [7:0] m);
		add_inst(enc_i(OP_ADI, 2'd0, 2'd3, m));
		add_wwd(2'd3, sext8(m));
	endtask

	// Target is PC+1 plus the offset, so a taken branch skips off words
	task automatic add_branch(input opcode_e op, input logic [1:0] rs, input logic [1:0] rt,
			input logic [15:0] va, input logic [15:0] vb, input logic [7:0] off);
		bit ran;
		bit taken;
		ran   = (skip_left == 0);
		taken = (op == OP_BEQ) ? (va == vb) : (va != vb);
		add_inst(enc_i(op, rs, rt, off));
		if (ran && taken)
			skip_left = int'(off);
	endtask

	task automatic add_jump(input logic [11:0] target);
		bit ran;
		ran = (skip_left == 0);
		add_inst({OP_JMP, target});
		if (ran)
			skip_left = int'(target) - prog.size();
	endtask

	task automatic add_halt();
		add_inst(enc_r(FN_HLT, 2'd0, 2'd0, 2'd0));
		skip_left = 1 << 20;
	endtask

	task automatic wait_halt();
		int cycles;
		cycles = 0;
		while (!is_halted) begin
			@(negedge clk);
			cycles++;
			if (cycles > HALT_TIMEOUT)
				fail_now("Timeout: the CPU never reached HALT");
		end
	endtask

	task automatic wait_words();
		int cycles;
		cycles = 0;
		while (got_words.size() < exp_words.size()) begin
			@(negedge clk);
			cycles++;
			if (cycles > WORD_TIMEOUT)
				fail_now("Timeout: fewer output words arrived than the program emits");
		end
	endtask

	task automatic run_program();
		int unsigned reqs_at_halt;
		@(posedge clk);
		reset_n <= 1'b0;
		got_words.delete();
		u_mem.fill_pattern();
		foreach (prog[i])
			u_mem.load_word(i, prog[i]);
		repeat (5) @(posedge clk);
		reset_n <= 1'b1;
		wait_halt();
		wait_words();
		check_count("num_inst", 16'(path_len), num_inst);
		foreach (exp_words[i])
			check_word($sformatf("out_data[%0d]", i), exp_words[i], got_words[i]);
		// Halted CPU stays put with the memory bus quiet
		reqs_at_halt = u_mem.req_count;
		repeat (20) begin
			@(negedge clk);
			if (!is_halted)
				fail_now("is_halted dropped after HLT");
			if (mem_req)
				fail_now("a memory request was raised after HLT");
		end
		if (u_mem.req_count != reqs_at_halt)
			fail_now("the memory saw new requests after HLT");
		if (got_words.size() != exp_words.size())
			fail_now("an output word arrived that the program path does not emit");
		check_count("num_inst", 16'(path_len), num_inst);
	endtask

	task automatic test_alu(input bit stall);
		logic [15:0] r1;
		logic [15:0] r2;
		r1 = sext8(8'h5a);
		r2 = sext8(8'hf3);
		ack_stall = stall;
		start_program();
		add_inst(enc_i(OP_ADI, 2'd0, 2'd1, 8'h5a));
		add_inst(enc_i(OP_ADI, 2'd0, 2'd2, 8'hf3));
		add_inst(enc_r(FN_ADD, 2'd1, 2'd2, 2'd3));
		add_wwd(2'd3, r1 + r2);
		add_inst(enc_r(FN_SUB, 2'd1, 2'd2, 2'd3));
		add_wwd(2'd3, r1 - r2);
		add_inst(enc_r(FN_AND, 2'd1, 2'd2, 2'd3));
		add_wwd(2'd3, r1 & r2);
		add_inst(enc_r(FN_ORR, 2'd1, 2'd2, 2'd3));
		add_wwd(2'd3, r1 | r2);
		add_inst(enc_r(FN_NOT, 2'd1, 2'd0, 2'd3));
		add_wwd(2'd3, ~r1);
		add_inst(enc_i(OP_ADI, 2'd1, 2'd3, 8'h9c));
		add_wwd(2'd3, r1 + sext8(8'h9c));
		add_halt();
		run_program();
		ack_stall = 1'b0;
	endtask

	task automatic test_load_store();
		logic [15:0] v1;
		logic [15:0] v3;
		logic [15:0] base;
		v1   = sext8(8'h6d);
		v3   = sext8(8'h91);
		base = sext8(8'h40);
		start_program();
		add_inst(enc_i(OP_ADI, 2'd0, 2'd1, 8'h6d));
		add_inst(enc_i(OP_ADI, 2'd0, 2'd3, 8'h91));
		add_inst(enc_i(OP_ADI, 2'd0, 2'd2, 8'h40));
		add_inst(enc_i(OP_SWD, 2'd2, 2'd1, 8'h05));
		add_inst(enc_i(OP_SWD, 2'd2, 2'd3, 8'hfe));
		// Read back swapped so each value crosses memory
		add_inst(enc_i(OP_LWD, 2'd2, 2'd3, 8'h05));
		add_inst(enc_i(OP_LWD, 2'd2, 2'd1, 8'hfe));
		add_wwd(2'd3, v1);
		add_wwd(2'd1, v3);
		add_halt();
		run_program();
		check_mem(base + sext8(8'h05), v1);
		check_mem(base + sext8(8'hfe), v3);
	endtask

	task automatic test_branch();
		start_program();
		add_inst(enc_i(OP_ADI, 2'd0, 2'd1, 8'h07));
		add_inst(enc_i(OP_ADI, 2'd0, 2'd2, 8'h07));
		add_branch(OP_BEQ, 2'd1, 2'd2, 16'h0007, 16'h0007, 8'd2);
		add_marker(8'h11);
		add_marker(8'h12);
		add_branch(OP_BNE, 2'd1, 2'd2, 16'h0007, 16'h0007, 8'd2);
		add_marker(8'h13);
		add_inst(enc_i(OP_ADI, 2'd0, 2'd2, 8'hfb));
		add_branch(OP_BEQ, 2'd1, 2'd2, 16'h0007, sext8(8'hfb), 8'd2);
		add_marker(8'h14);
		add_branch(OP_BNE, 2'd1, 2'd2, 16'h0007, sext8(8'hfb), 8'd2);
		add_marker(8'h15);
		add_marker(8'h16);
		add_halt();
		run_program();
	endtask

	task automatic test_jump();
		start_program();
		add_marker(8'h21);
		add_jump(12'd5);
		add_marker(8'h22);
		add_marker(8'h23);
		add_halt();
		run_program();
		foreach (got_words[i])
			if (got_words[i].value == 16'h0022)
				fail_now("the marker skipped by JMP was emitted");
	endtask

	task automatic test_halt();
		start_program();
		add_inst(enc_i(OP_ADI, 2'd0, 2'd1, 8'h03));
		add_inst(enc_r(FN_ADD, 2'd1, 2'd1, 2'd2));
		add_wwd(2'd2, 16'h0006);
		add_halt();
		// Never reached
		add_marker(8'h33);
		run_program();
	endtask

	initial begin
		reset_n   = 1'b0;
		out_ack   = 1'b0;
		ack_stall = 1'b0;
		seed      = 32'h65e8a040;
		test_alu(1'b0);
		test_load_store();
		test_branch();
		test_jump();
		test_halt();
		test_alu(1'b1);
		$display("=== PASS ===");
		$finish;
	end

endmodule

// File: tsc_multicycle.f
+incdir+include
hw/tsc_pkg.sv
hw/mem_port.sv
hw/register_file.sv
hw/alu.sv
hw/control_fsm.sv
hw/datapath.sv
hw/output_port.sv
hw/tsc_cpu.sv
verif/mem_model.sv
verif/tb_tsc_cpu.sv
